// ==== source/isaPkg.sv ====
`default_nettype none

package isaPkg;

   parameter int DataWidth = 16;

   typedef logic [DataWidth-1:0] word_t;

   typedef enum logic [4:0] {
      ADD    = 5'h00,
      ADDI   = 5'h01,
      ADC    = 5'h02,
      SUB    = 5'h03,
      SUBI   = 5'h04,
      CMP    = 5'h05,
      CMPI   = 5'h06,
      AND    = 5'h07,
      OR     = 5'h08,
      XOR    = 5'h09,
      NOT    = 5'h0a,
      LSL    = 5'h0b,
      LSR    = 5'h0c,
      ASR    = 5'h0d,
      LUI    = 5'h0e,
      LLI    = 5'h0f,
      LDW    = 5'h10,
      STW    = 5'h11,
      BRANCH = 5'h12
   } opcode_t;

   typedef enum logic [2:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      BWL = 3'd5,
      RET = 3'd6
   } branch_t;

   typedef enum logic [3:0] {
      FnAdd,
      FnAdc,
      FnSub,
      FnAnd,
      FnOr,
      FnXor,
      FnNot,
      FnLsl,
      FnLsr,
      FnAsr,
      FnLui,
      FnLli,
      FnPassA
   } aluFn_t;

   typedef struct packed {
      opcode_t    opcode;   // 15:11
      logic [2:0] rd;       // 10:8, branch code on BRANCH
      logic [2:0] ra;       // 7:5
      logic [2:0] rb;       // 4:2
      logic [1:0] lo;       // low end of both immediates
   } instr_t;

   typedef struct packed {
      logic z;
      logic n;
      logic v;
      logic c;
   } flags_t;

   function automatic word_t shortImm(instr_t i);
      return word_t'({i.rb, i.lo});   // bits 4:0, zero extended
   endfunction

   function automatic word_t longImm(instr_t i);
      return {{(DataWidth-8){i.ra[2]}}, i.ra, i.rb, i.lo};   // bits 7:0, sign extended
   endfunction

endpackage

`default_nettype wire

// ==== source/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

   import isaPkg::*;

   typedef enum logic [1:0] {
      Op2Rb,
      Op2Short,
      Op2Long
   } op2Sel_t;

   typedef enum logic {
      Rs1Ra,
      Rs1Rd
   } rs1Sel_t;

   typedef enum logic {
      WdAlu,
      WdMem
   } wdSel_t;

   typedef enum logic [1:0] {
      PcInc,
      PcTarget,
      PcLink
   } pcSel_t;

   typedef enum logic [1:0] {
      AdPc,
      AdAlu,
      AdStore
   } adSel_t;

   typedef struct packed {
      aluFn_t  aluFn;
      op2Sel_t op2Sel;
      rs1Sel_t rs1Sel;
      wdSel_t  wdSel;
      pcSel_t  pcSel;
      logic    regWe;
      logic    pcWe;
      logic    lrWe;
      logic    irWe;
      logic    aluWe;
      logic    sample;     // capture BusIn at the next edge
      logic    carryIn;    // status C for ADC
      adSel_t  adSel;
   } ctrl_t;

   typedef struct packed {
      word_t ad;
      logic  ale;
      logic  nMe;
      logic  nOe;
      logic  nWe;
   } busOut_t;

endpackage

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu import isaPkg::*; (
   input  word_t  A,
   input  word_t  B,
   input  aluFn_t Fn,
   input  logic   CarryIn,
   output word_t  Result,
   output flags_t Flags
);

   localparam int Msb = DataWidth - 1;

   logic [DataWidth:0] sum;

   always_comb begin
      sum     = '0;
      Result  = A;
      Flags.c = 1'b0;
      Flags.v = 1'b0;
      case (Fn)
         FnAdd, FnAdc: begin
            sum     = {1'b0, A} + {1'b0, B} + {{DataWidth{1'b0}}, CarryIn && (Fn == FnAdc)};
            Result  = sum[Msb:0];
            Flags.c = sum[DataWidth];
            Flags.v = (A[Msb] == B[Msb]) && (Result[Msb] != A[Msb]);
         end
         FnSub: begin
            sum     = {1'b0, A} + {1'b0, ~B} + 1'b1;
            Result  = sum[Msb:0];
            Flags.c = sum[DataWidth];   // set when no borrow
            Flags.v = (A[Msb] != B[Msb]) && (Result[Msb] != A[Msb]);
         end
         FnAnd:   Result = A & B;
         FnOr:    Result = A | B;
         FnXor:   Result = A ^ B;
         FnNot:   Result = ~A;
         FnLsl:   Result = A << B[3:0];
         FnLsr:   Result = A >> B[3:0];
         FnAsr:   Result = word_t'($signed(A) >>> B[3:0]);
         FnLui:   Result = {B[7:0], 8'h00};
         FnLli:   Result = {A[Msb:8], B[7:0]};
         default: Result = A;
      endcase
      Flags.z = (Result == '0);
      Flags.n = Result[Msb];
   end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile import isaPkg::*; (
   input  logic       Clock,
   input  logic       nReset,
   input  logic [2:0] RaAddr,
   input  logic [2:0] RbAddr,
   input  logic [2:0] WrAddr,
   input  word_t      WrData,
   input  logic       We,
   output word_t      RaData,
   output word_t      RbData
);

   word_t regs [8];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (We) begin
         regs[WrAddr] <= WrData;
      end
   end

   assign RaData = regs[RaAddr];
   assign RbData = regs[RbAddr];

   // write address comes from the instruction register
   knownWrAddr: assert property (@(posedge Clock) disable iff (!nReset)
      We |-> !$isunknown(WrAddr));

endmodule

`default_nettype wire

// ==== source/progCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

module progCounter import isaPkg::*, ctrlPkg::*; #(
   parameter word_t ResetVector = '0
) (
   input  logic  Clock,
   input  logic  nReset,
   input  ctrl_t Ctrl,
   input  word_t Target,
   output word_t Pc,
   output word_t Lr
);

   word_t pcNext;

   assign pcNext = Pc + word_t'(1);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Pc <= ResetVector;
         Lr <= '0;
      end else begin
         if (Ctrl.pcWe) begin
            case (Ctrl.pcSel)
               PcTarget: Pc <= Target;
               PcLink:   Pc <= Lr;   // return
               default:  Pc <= pcNext;
            endcase
         end
         if (Ctrl.lrWe)
            Lr <= pcNext;   // word after the call
      end
   end

endmodule

`default_nettype wire

// ==== source/busInterface.sv ====
`timescale 1ns/1ns
`default_nettype none

module busInterface import isaPkg::*, ctrlPkg::*; (
   input  logic       Clock,
   input  logic       nReset,
   input  ctrl_t      Ctrl,
   input  word_t      BusIn,
   input  word_t      Pc,
   input  word_t      AluResult,
   input  word_t      StoreData,   // register read port A
   input  word_t      RegB,
   output word_t      Ad,
   output instr_t     Instr,
   output word_t      MemData,     // register write-back word
   output word_t      AluReg,
   output logic [2:0] RegAddrA,
   output word_t      OpA,
   output word_t      OpB
);

   word_t dataIn;

   always_ff @(posedge Clock) begin
      if (Ctrl.sample)
         dataIn <= BusIn;
      if (Ctrl.aluWe)
         AluReg <= AluResult;
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         Instr <= '0;
      else if (Ctrl.irWe)
         Instr <= instr_t'(dataIn);
   end

   always_comb begin
      case (Ctrl.adSel)
         AdAlu:   Ad = AluReg;
         AdStore: Ad = StoreData;
         default: Ad = Pc;
      endcase
   end

   always_comb begin
      case (Ctrl.op2Sel)
         Op2Short: OpB = shortImm(Instr);
         Op2Long:  OpB = longImm(Instr);
         default:  OpB = RegB;
      endcase
   end

   assign OpA      = (Instr.opcode == BRANCH) ? Pc : StoreData;   // branch target is pc relative
   assign RegAddrA = (Ctrl.rs1Sel == Rs1Rd) ? Instr.rd : Instr.ra;
   assign MemData  = (Ctrl.wdSel == WdMem) ? dataIn : AluResult;

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit import isaPkg::*, ctrlPkg::*; (
   input  logic    Clock,
   input  logic    nReset,
   input  instr_t  Instr,
   input  flags_t  AluFlags,
   output ctrl_t   Ctrl,
   output busOut_t Strobes
);

   typedef enum logic [3:0] {F1, F2, F3, F4, E1, E2, E3, E4, E5} phase_t;

   phase_t  phase;
   flags_t  statusReg;
   logic    statusWe;
   logic    memOp;
   logic    taken;
   branch_t branchCode;

   assign memOp      = Instr.opcode inside {LDW, STW};
   assign branchCode = branch_t'(Instr.rd);

   function automatic aluFn_t aluFnOf(opcode_t op);
      case (op)
         ADD, ADDI:           return FnAdd;
         ADC:                 return FnAdc;
         SUB, SUBI, CMP, CMPI: return FnSub;
         AND:                 return FnAnd;
         OR:                  return FnOr;
         XOR:                 return FnXor;
         NOT:                 return FnNot;
         LSL:                 return FnLsl;
         LSR:                 return FnLsr;
         ASR:                 return FnAsr;
         LUI:                 return FnLui;
         LLI:                 return FnLli;
         default:             return FnPassA;
      endcase
   endfunction

   function automatic op2Sel_t op2Of(opcode_t op);
      case (op)
         ADDI, SUBI, CMPI, LSL, LSR, ASR: return Op2Short;
         LUI, LLI:                        return Op2Long;
         default:                         return Op2Rb;
      endcase
   endfunction

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase <= F1;
      end else begin
         case (phase)
            F1:      phase <= F2;
            F2:      phase <= F3;
            F3:      phase <= F4;
            F4:      phase <= E1;
            E1:      phase <= memOp ? E2 : F1;
            E2:      phase <= E3;
            E3:      phase <= E4;
            E4:      phase <= E5;
            default: phase <= F1;
         endcase
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusReg <= '0;
      else if (statusWe)
         statusReg <= AluFlags;
   end

   always_comb begin
      case (branchCode)
         BR, BWL: taken = 1'b1;
         BNE:     taken = !statusReg.z;
         BE:      taken = statusReg.z;
         BLT:     taken = statusReg.n ^ statusReg.v;
         BGE:     taken = !(statusReg.n ^ statusReg.v);
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      Ctrl.aluFn   = FnPassA;
      Ctrl.op2Sel  = Op2Rb;
      Ctrl.rs1Sel  = Rs1Ra;
      Ctrl.wdSel   = WdAlu;
      Ctrl.pcSel   = PcInc;
      Ctrl.regWe   = 1'b0;
      Ctrl.pcWe    = 1'b0;
      Ctrl.lrWe    = 1'b0;
      Ctrl.irWe    = 1'b0;
      Ctrl.aluWe   = 1'b0;
      Ctrl.sample  = 1'b0;
      Ctrl.carryIn = statusReg.c;
      Ctrl.adSel   = AdPc;
      Strobes.ad   = '0;
      Strobes.ale  = 1'b0;
      Strobes.nMe  = 1'b1;
      Strobes.nOe  = 1'b1;
      Strobes.nWe  = 1'b1;
      statusWe     = 1'b0;
      case (phase)
         F1: Strobes.ale = nReset;   // pc on the bus, low while in reset
         F2: begin
            Strobes.nMe = 1'b0;
            Strobes.nOe = 1'b0;
         end
         F3: begin
            Strobes.nMe = 1'b0;
            Strobes.nOe = 1'b0;
            Ctrl.sample = 1'b1;
         end
         F4: Ctrl.irWe = 1'b1;
         E1: begin
            case (Instr.opcode)
               ADD, ADDI, ADC, SUB, SUBI, CMP, CMPI, AND, OR, XOR, NOT, LSL, LSR, ASR,
               LUI, LLI: begin
                  Ctrl.aluFn  = aluFnOf(Instr.opcode);
                  Ctrl.op2Sel = op2Of(Instr.opcode);
                  Ctrl.rs1Sel = (Instr.opcode == LLI) ? Rs1Rd : Rs1Ra;   // keeps rd high byte
                  Ctrl.regWe  = !(Instr.opcode inside {CMP, CMPI});
                  statusWe    = !(Instr.opcode inside {LUI, LLI});
                  Ctrl.pcWe   = 1'b1;
               end
               LDW, STW: begin
                  Ctrl.aluFn  = FnAdd;      // ra + offset
                  Ctrl.op2Sel = Op2Short;
                  Ctrl.aluWe  = 1'b1;
               end
               BRANCH: begin
                  Ctrl.aluFn  = FnAdd;      // pc + offset
                  Ctrl.op2Sel = Op2Long;
                  Ctrl.pcWe   = 1'b1;
                  if (branchCode == RET) begin
                     Ctrl.pcSel = PcLink;
                  end else if (taken) begin
                     Ctrl.pcSel = PcTarget;
                     Ctrl.lrWe  = (branchCode == BWL);
                  end
               end
               default: Ctrl.pcWe = 1'b1;   // unknown opcode skipped
            endcase
         end
         E2: begin
            Strobes.ale = 1'b1;
            Ctrl.adSel  = AdAlu;
         end
         E3: begin
            Ctrl.adSel = AdAlu;
            if (Instr.opcode == LDW) begin
               Strobes.nMe = 1'b0;
               Strobes.nOe = 1'b0;
            end else begin
               Ctrl.rs1Sel = Rs1Rd;   // store word into the alu register
               Ctrl.aluWe  = 1'b1;
            end
         end
         E4: begin
            Ctrl.adSel  = AdAlu;
            Strobes.nMe = 1'b0;
            if (Instr.opcode == LDW) begin
               Strobes.nOe = 1'b0;
               Ctrl.sample = 1'b1;
            end else begin
               Strobes.nWe = 1'b0;
            end
         end
         E5: begin
            Ctrl.pcWe = 1'b1;
            if (Instr.opcode == LDW) begin
               Ctrl.wdSel = WdMem;
               Ctrl.regWe = 1'b1;
            end else begin
               Ctrl.rs1Sel = Rs1Rd;   // data held past the write edge
               Ctrl.adSel  = AdStore;
            end
         end
         default: ;
      endcase
   end

   noReadWrite: assert property (@(posedge Clock) disable iff (!nReset)
      !(!Strobes.nOe && !Strobes.nWe));

   aleIdle: assert property (@(posedge Clock) disable iff (!nReset)
      Strobes.ale |-> Strobes.nMe);

endmodule

`default_nettype wire

// ==== source/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCore import isaPkg::*, ctrlPkg::*; #(
   parameter word_t ResetVector = '0
) (
   input  logic    Clock,
   input  logic    nReset,
   input  word_t   BusIn,
   output busOut_t BusOut
);

   ctrl_t      ctrl;
   busOut_t    strobes;
   instr_t     instr;
   flags_t     aluFlags;
   word_t      opA;
   word_t      opB;
   word_t      aluResult;
   word_t      raData;
   word_t      rbData;
   word_t      wrData;
   word_t      pc;
   word_t      ad;
   logic [2:0] raAddr;

   controlUnit uControl (
      .Clock    (Clock),
      .nReset   (nReset),
      .Instr    (instr),
      .AluFlags (aluFlags),
      .Ctrl     (ctrl),
      .Strobes  (strobes)
   );

   alu uAlu (
      .A       (opA),
      .B       (opB),
      .Fn      (ctrl.aluFn),
      .CarryIn (ctrl.carryIn),
      .Result  (aluResult),
      .Flags   (aluFlags)
   );

   regFile uRegs (
      .Clock  (Clock),
      .nReset (nReset),
      .RaAddr (raAddr),
      .RbAddr (instr.rb),
      .WrAddr (instr.rd),
      .WrData (wrData),
      .We     (ctrl.regWe),
      .RaData (raData),
      .RbData (rbData)
   );

   progCounter #(
      .ResetVector (ResetVector)
   ) uPc (
      .Clock  (Clock),
      .nReset (nReset),
      .Ctrl   (ctrl),
      .Target (aluResult),
      .Pc     (pc),
      .Lr     ()
   );

   busInterface uBus (
      .Clock     (Clock),
      .nReset    (nReset),
      .Ctrl      (ctrl),
      .BusIn     (BusIn),
      .Pc        (pc),
      .AluResult (aluResult),
      .StoreData (raData),
      .RegB      (rbData),
      .Ad        (ad),
      .Instr     (instr),
      .MemData   (wrData),
      .AluReg    (),
      .RegAddrA  (raAddr),
      .OpA       (opA),
      .OpB       (opB)
   );

   assign BusOut = '{ad: ad, ale: strobes.ale, nMe: strobes.nMe, nOe: strobes.nOe,
                     nWe: strobes.nWe};

endmodule

`default_nettype wire

// ==== tb/memModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module memModel import isaPkg::*, ctrlPkg::*; (
   input  logic    Clock,
   input  logic    nReset,
   input  busOut_t Bus,
   input  logic    Clear,
   input  logic    LoadEn,
   input  word_t   LoadAddr,
   input  word_t   LoadData,
   output word_t   BusIn
);

   word_t mem [1024];
   word_t addr;
   int    cycle;
   int    aleCount;
   int    aleCycle [64];
   word_t aleAddr [64];
   int    writeCount;
   logic  bothLow;

   assign BusIn = (!Bus.nMe && !Bus.nOe && Bus.nWe) ? mem[addr[9:0]] : '0;

   always @(posedge Clock) begin
      if (Clear) begin
         for (int i = 0; i < 1024; i++)
            mem[i] <= word_t'(i) * 16'h9e37 ^ 16'h5a5a;   // unused words differ by address
      end else if (LoadEn) begin
         mem[LoadAddr[9:0]] <= LoadData;
      end else if (nReset && !Bus.nMe && !Bus.nWe) begin
         mem[addr[9:0]] <= Bus.ad;
      end
      if (Bus.ale)
         addr <= Bus.ad;   // address phase
   end

   // cycle 0 is the first cycle after reset release
   always @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         cycle      <= 0;
         aleCount   <= 0;
         writeCount <= 0;
         bothLow    <= 1'b0;
      end else begin
         cycle <= cycle + 1;
         if (Bus.ale && aleCount < 64) begin
            aleCycle[aleCount] <= cycle;
            aleAddr[aleCount]  <= Bus.ad;
            aleCount           <= aleCount + 1;
         end
         if (!Bus.nMe && !Bus.nWe)
            writeCount <= writeCount + 1;
         if (!Bus.nOe && !Bus.nWe)
            bothLow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTb import isaPkg::*, ctrlPkg::*; ();

   localparam word_t DataBase      = 16'h0100;
   localparam int    ProgWords     = 31 + 98 + 8 + 41 + 7;   // words of the five programs
   localparam int    TimeoutCycles = ProgWords * 9 + 500;

   logic    Clock;
   logic    nReset;
   logic    clear;
   logic    loadEn;
   word_t   loadAddr;
   word_t   loadData;
   word_t   busIn;
   busOut_t busOut;

   word_t prog [$];
   int    errors;
   int    checks;
   int    testErrors;
   int    tests;
   logic  idleBad;

   cpuCore #(
      .ResetVector (16'h0000)
   ) u_dut (
      .Clock  (Clock),
      .nReset (nReset),
      .BusIn  (busIn),
      .BusOut (busOut)
   );

   memModel u_mem (
      .Clock    (Clock),
      .nReset   (nReset),
      .Bus      (busOut),
      .Clear    (clear),
      .LoadEn   (loadEn),
      .LoadAddr (loadAddr),
      .LoadData (loadData),
      .BusIn    (busIn)
   );

   initial begin
      Clock = 1'b0;
      forever #10 Clock = ~Clock;
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < TimeoutCycles) begin
         @(posedge Clock);
         cycles++;
      end
      $display("timeout after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
   end

   function automatic word_t encR(opcode_t op, logic [2:0] rd, logic [2:0] ra, logic [2:0] rb);
      return {op, rd, ra, rb, 2'b00};
   endfunction

   function automatic word_t encI(opcode_t op, logic [2:0] rd, logic [2:0] ra, logic [4:0] imm);
      return {op, rd, ra, imm};
   endfunction

   function automatic word_t encL(opcode_t op, logic [2:0] rd, logic [7:0] imm);
      return {op, rd, imm};   // branches carry the condition in rd
   endfunction

   function automatic word_t memAt(word_t a);
      return u_mem.mem[a[9:0]];
   endfunction

   // outcome of a compare of a with b, signed for BLT and BGE
   function automatic logic condTaken(branch_t code, word_t a, word_t b);
      case (code)
         BNE:     return a != b;
         BE:      return a == b;
         BLT:     return $signed(a) < $signed(b);
         BGE:     return $signed(a) >= $signed(b);
         default: return 1'b1;
      endcase
   endfunction

   task automatic emit(word_t w);
      prog.push_back(w);
   endtask

   task automatic loadConst(logic [2:0] rd, word_t value);
      emit(encL(LUI, rd, value[15:8]));
      emit(encL(LLI, rd, value[7:0]));
   endtask

   task automatic opStore(word_t instr, int slot);
      emit(instr);
      emit(encI(STW, 3, 7, 5'(slot)));
   endtask

   task automatic checkWord(string name, word_t expected, word_t actual);
      checks++;
      assert (actual === expected) else begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         testErrors++;
      end
   endtask

   task automatic checkTrue(string what, logic ok);
      checks++;
      assert (ok) else begin
         $display("%s", what);
         testErrors++;
      end
   endtask

   // memory is cleared and loaded while the core is held in reset
   task automatic startProgram();
      @(posedge Clock);
      #2;
      nReset = 1'b0;
      clear  = 1'b1;
      @(posedge Clock);
      #2;
      clear = 1'b0;
      foreach (prog[i]) begin
         loadEn   = 1'b1;
         loadAddr = word_t'(i);
         loadData = prog[i];
         @(posedge Clock);
         #2;
      end
      loadEn = 1'b0;
      @(negedge Clock);
      idleBad = busOut.ale || !(busOut.nMe && busOut.nOe && busOut.nWe);
      repeat (8) @(posedge Clock);
      #2;
      nReset = 1'b1;
   endtask

   task automatic runToHalt(string name, word_t haltAddr);
      int hits;
      int cycles;
      hits   = 0;
      cycles = 0;
      while (hits < 2 && cycles < prog.size() * 9 + 20) begin
         @(negedge Clock);
         if (busOut.ale && busOut.ad == haltAddr)
            hits++;
         cycles++;
      end
      checkTrue($sformatf("%s: program never reached its halt loop", name), hits == 2);
   endtask

   task automatic finishTest(string name);
      tests++;
      errors += testErrors;
      if (testErrors == 0)
         $display("test %s passed", name);
      else
         $display("test %s: %0d errors", name, testErrors);
      testErrors = 0;
   endtask

   task automatic aluOps();
      word_t       a;
      word_t       b;
      word_t       expected [12];
      logic [4:0]  imm;
      logic [3:0]  sh;
      logic [16:0] wide;
      a    = word_t'($urandom);
      b    = word_t'($urandom);
      imm  = 5'($urandom % 32);
      sh   = 4'($urandom % 16);
      wide = {1'b0, a} + {1'b0, b};
      expected = '{a + b, a + word_t'(imm), a - b, a - word_t'(imm), a & b, a | b, a ^ b,
                   ~a, a << sh, a >> sh, a[15] ? ~(~a >> sh) : a >> sh,
                   a + b + word_t'(wide[16])};
      prog.delete();
      emit(encL(LUI, 7, DataBase[15:8]));
      loadConst(1, a);
      loadConst(2, b);
      opStore(encR(ADD, 3, 1, 2), 0);
      opStore(encI(ADDI, 3, 1, imm), 1);
      opStore(encR(SUB, 3, 1, 2), 2);
      opStore(encI(SUBI, 3, 1, imm), 3);
      opStore(encR(AND, 3, 1, 2), 4);
      opStore(encR(OR, 3, 1, 2), 5);
      opStore(encR(XOR, 3, 1, 2), 6);
      opStore(encR(NOT, 3, 1, 0), 7);
      opStore(encI(LSL, 3, 1, {1'b0, sh}), 8);
      opStore(encI(LSR, 3, 1, {1'b0, sh}), 9);
      opStore(encI(ASR, 3, 1, {1'b0, sh}), 10);
      emit(encR(ADD, 4, 1, 2));   // sets carry for ADC
      opStore(encR(ADC, 3, 1, 2), 11);
      emit(encL(BRANCH, BR, 8'd0));
      startProgram();
      runToHalt("aluOps", word_t'(prog.size() - 1));
      for (int k = 0; k < 12; k++)
         checkWord($sformatf("aluOps[%0d]", k), expected[k], memAt(DataBase + word_t'(k)));
      finishTest("aluOps");
   endtask

   task automatic flagBranches();
      branch_t    conds [10];
      word_t      a;
      word_t      b;
      word_t      expected [10];
      logic [4:0] imm;
      conds = '{BNE, BE, BLT, BGE, BNE, BE, BLT, BGE, BE, BLT};
      prog.delete();
      emit(encL(LUI, 7, DataBase[15:8]));
      for (int k = 0; k < 10; k++) begin
         a   = word_t'($urandom);
         b   = word_t'($urandom);
         imm = 5'($urandom % 32);
         if (k >= 4 && k < 8)
            b = a;   // equal operands
         if (k >= 8)
            b = word_t'(imm);
         if (k == 8)
            a = b;
         loadConst(1, a);
         if (k >= 8) begin
            emit(encI(CMPI, 0, 1, imm));
         end else begin
            loadConst(2, b);
            emit(encR(CMP, 0, 1, 2));
         end
         emit(encL(BRANCH, conds[k], 8'd3));
         emit(encL(LLI, 5, 8'h80 + 8'(k)));   // fall-through marker
         emit(encL(BRANCH, BR, 8'd2));
         emit(encL(LLI, 5, 8'h10 + 8'(k)));   // taken marker
         emit(encI(STW, 5, 7, 5'(k)));
         expected[k] = condTaken(conds[k], a, b) ? 16'h0010 + word_t'(k)
                                                 : 16'h0080 + word_t'(k);
      end
      emit(encL(BRANCH, BR, 8'd0));
      startProgram();
      runToHalt("flagBranches", word_t'(prog.size() - 1));
      for (int k = 0; k < 10; k++)
         checkWord($sformatf("flagBranches[%0d]", k), expected[k], memAt(DataBase + word_t'(k)));
      finishTest("flagBranches");
   endtask

   task automatic linkReturn();
      prog.delete();
      emit(encL(LUI, 7, DataBase[15:8]));
      emit(encL(BRANCH, BWL, 8'd4));   // call the routine at word 5
      emit(encL(LLI, 5, 8'h22));
      emit(encI(STW, 5, 7, 5'd1));
      emit(encL(BRANCH, BR, 8'd0));
      emit(encL(LLI, 6, 8'h11));
      emit(encI(STW, 6, 7, 5'd0));
      emit(encL(BRANCH, RET, 8'd0));
      startProgram();
      runToHalt("linkReturn", 16'd4);
      checkWord("linkReturn routine", 16'h0011, memAt(DataBase));
      checkWord("linkReturn resume", 16'h0022, memAt(DataBase + 16'd1));
      finishTest("linkReturn");
   endtask

   task automatic loadStore();
      word_t addr [4];
      word_t val [4];
      prog.delete();
      for (int i = 0; i < 4; i++) begin
         addr[i] = DataBase + word_t'(i * 192) + word_t'($urandom % 192);
         val[i]  = word_t'($urandom);
         loadConst(1, addr[i]);
         loadConst(2, val[i]);
         emit(encI(STW, 2, 1, 5'd0));
      end
      for (int i = 0; i < 4; i++) begin
         loadConst(1, addr[i]);
         emit(encI(LDW, 3, 1, 5'd0));
         emit(encI(ADDI, 3, 3, 5'(i + 1)));
         emit(encI(STW, 3, 1, 5'd0));
      end
      emit(encL(BRANCH, BR, 8'd0));
      startProgram();
      runToHalt("loadStore", word_t'(prog.size() - 1));
      for (int i = 0; i < 4; i++)
         checkWord($sformatf("loadStore[%h]", addr[i]), val[i] + word_t'(i + 1), memAt(addr[i]));
      finishTest("loadStore");
   endtask

   task automatic busTiming();
      int gaps [7];
      int fetch [$];
      gaps = '{5, 5, 9, 9, 5, 5, 5};
      prog.delete();
      emit(encI(ADDI, 1, 1, 5'd5));
      emit(encL(LUI, 7, DataBase[15:8]));
      emit(encI(STW, 1, 7, 5'd0));
      emit(encI(LDW, 2, 7, 5'd0));
      emit(encR(CMP, 0, 1, 2));
      emit(encL(BRANCH, BE, 8'd1));
      emit(encL(BRANCH, BR, 8'd0));
      startProgram();
      runToHalt("busTiming", 16'd6);
      repeat (2) @(negedge Clock);   // let the last ALE reach the log
      checkTrue("busTiming: strobes not idle during reset", !idleBad);
      checkTrue("busTiming: nOe and nWe were low together", !u_mem.bothLow);
      checkWord("busTiming write cycles", 16'd1, word_t'(u_mem.writeCount));
      for (int i = 0; i < u_mem.aleCount; i++)
         if (u_mem.aleAddr[i] < DataBase)
            fetch.push_back(u_mem.aleCycle[i]);
      checkTrue("busTiming: too few instruction fetches logged", fetch.size() >= 8);
      if (fetch.size() >= 8) begin
         checkWord("busTiming first fetch", 16'd0, word_t'(fetch[0]));
         for (int i = 0; i < 7; i++)
            checkWord($sformatf("busTiming gap %0d", i), word_t'(gaps[i]),
                      word_t'(fetch[i + 1] - fetch[i]));
      end
      checkWord("busTiming stored word", 16'd5, memAt(DataBase));
      finishTest("busTiming");
   endtask

   initial begin
      void'($urandom(32'hab35_7a7f));
      nReset     = 1'b0;
      clear      = 1'b0;
      loadEn     = 1'b0;
      loadAddr   = '0;
      loadData   = '0;
      errors     = 0;
      checks     = 0;
      testErrors = 0;
      tests      = 0;
      idleBad    = 1'b0;
      aluOps();
      flagBranches();
      linkReturn();
      loadStore();
      busTiming();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
source/isaPkg.sv
source/ctrlPkg.sv
source/alu.sv
source/regFile.sv
source/progCounter.sv
source/busInterface.sv
source/controlUnit.sv
source/cpuCore.sv
tb/memModel.sv
tb/cpuTb.sv

// ==== Makefile ====
.PHONY: all run check clean

all: check

obj_dir/VcpuTb: src.f $(wildcard source/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -f src.f --top-module cpuTb -Mdir obj_dir -o VcpuTb

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee sim.log

check: run
	@if grep -q "Simulation failed" sim.log; then \
		echo "check: failure reported"; exit 1; \
	elif ! grep -q "Simulation completed successfully" sim.log; then \
		echo "check: run did not complete"; exit 1; \
	else \
		echo "check: ok"; \
	fi

clean:
	rm -rf obj_dir sim.log
